// ==== vlog.f ====
source/mul_pkg.sv
source/partial_product_if.sv
source/wallace_8x8.sv
source/partial_product_stage.sv
source/accumulate_stage.sv
source/wallace_mul32.sv
bench/tb_wallace_mul32.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_wallace_mul32 \
    -Mdir obj_dir

./obj_dir/Vtb_wallace_mul32 > sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== bench/tb_wallace_mul32.sv ====
`timescale 1ns/100ps

module tb_wallace_mul32;

    localparam int TABLE_ROWS     = 16;
    localparam int RANDOM_ROWS    = 40;
    localparam int ROWS           = TABLE_ROWS + RANDOM_ROWS;
    localparam int TOTAL_ROWS     = ROWS + TABLE_ROWS;  // table is replayed for timing
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_ROWS + RESET_CYCLES + 50;

    typedef struct {
        int                row;
        mul_pkg::product_t expected;
        int                accept_cycle;
        bit                timed;
    } pending_t;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    logic              a_signed;
    logic              b_signed;
    logic              out_valid;
    logic              out_ready;
    mul_pkg::product_t product;

    // table rows followed by random rows
    mul_pkg::operand_t tab_a   [ROWS];
    mul_pkg::operand_t tab_b   [ROWS];
    bit                tab_as  [ROWS];
    bit                tab_bs  [ROWS];
    mul_pkg::product_t tab_exp [ROWS];

    pending_t          pending [$];   // scoreboard in input order
    pending_t          item;
    int                seed;
    int                cycle;
    int                pass_count;
    int                fail_count;
    bit                random_ready;
    bit                timed_mode;
    int                last_timed_cycle;
    bit                hold_pending;
    mul_pkg::product_t held_product;

    wallace_mul32 dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .a_signed  (a_signed),
        .b_signed  (b_signed),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .product   (product)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // extend each operand by its select and multiply at 64 bits
    function automatic mul_pkg::product_t reference_product(
        input mul_pkg::operand_t x,
        input mul_pkg::operand_t y,
        input bit                xs,
        input bit                ys
    );
        mul_pkg::product_t xe;
        mul_pkg::product_t ye;
        xe = xs ? {{32{x[31]}}, x} : {32'd0, x};
        ye = ys ? {{32{y[31]}}, y} : {32'd0, y};
        return xe * ye;
    endfunction

    task automatic set_row(input int idx, input mul_pkg::operand_t ra, input mul_pkg::operand_t rb,
                           input bit ras, input bit rbs, input mul_pkg::product_t rexp);
        tab_a[idx]   = ra;
        tab_b[idx]   = rb;
        tab_as[idx]  = ras;
        tab_bs[idx]  = rbs;
        tab_exp[idx] = rexp;
    endtask

    task automatic load_rows();
        int r;
        // unsigned
        set_row(0,  32'hFFFFFFFF, 32'hFFFFFFFF, 1'b0, 1'b0, 64'hFFFFFFFE00000001);
        set_row(1,  32'h00000000, 32'h12345678, 1'b0, 1'b0, 64'h0000000000000000);
        set_row(2,  32'hDEADBEEF, 32'h00000000, 1'b0, 1'b0, 64'h0000000000000000);
        set_row(3,  32'h000000FF, 32'h000000FF, 1'b0, 1'b0, 64'h000000000000FE01);
        set_row(4,  32'h00FF0000, 32'h0000FF00, 1'b0, 1'b0, 64'h000000FE01000000);
        set_row(5,  32'hFF000000, 32'hFF000000, 1'b0, 1'b0, 64'hFE01000000000000);
        set_row(6,  32'h0000FFFF, 32'h0000FFFF, 1'b0, 1'b0, 64'h00000000FFFE0001);
        // signed
        set_row(7,  32'h80000000, 32'h80000000, 1'b1, 1'b1, 64'h4000000000000000);
        set_row(8,  32'hFFFFFFFF, 32'h00000005, 1'b1, 1'b1, 64'hFFFFFFFFFFFFFFFB);
        set_row(9,  32'hFFFFFFF9, 32'h00000003, 1'b1, 1'b1, 64'hFFFFFFFFFFFFFFEB);
        set_row(10, 32'h7FFFFFFF, 32'h7FFFFFFF, 1'b1, 1'b1, 64'h3FFFFFFF00000001);
        set_row(11, 32'h80000000, 32'h7FFFFFFF, 1'b1, 1'b1, 64'hC000000080000000);
        set_row(12, 32'hFFFFFFFF, 32'hFFFFFFFF, 1'b1, 1'b1, 64'h0000000000000001);
        // mixed signedness
        set_row(13, 32'hFFFFFFFE, 32'hFFFFFFFF, 1'b1, 1'b0, 64'hFFFFFFFE00000002);
        set_row(14, 32'h80000000, 32'hFFFFFFFD, 1'b0, 1'b1, 64'hFFFFFFFE80000000);
        set_row(15, 32'h80000000, 32'hFFFFFFFF, 1'b0, 1'b1, 64'hFFFFFFFF80000000);
        for (int i = TABLE_ROWS; i < ROWS; i++) begin
            tab_a[i]   = $random(seed);
            tab_b[i]   = $random(seed);
            r          = $random(seed);
            tab_as[i]  = r[0];
            tab_bs[i]  = r[1];
            tab_exp[i] = reference_product(tab_a[i], tab_b[i], tab_as[i], tab_bs[i]);
        end
    endtask

    task automatic record_check(input bit ok, input string msg);
        assert (ok) pass_count = pass_count + 1;
        else begin
            fail_count = fail_count + 1;
            $display("%s", msg);
        end
    endtask

    // present one row and hold it until accepted
    task automatic send_row(input int idx, output int waits);
        pending_t entry;
        a        = tab_a[idx];
        b        = tab_b[idx];
        a_signed = tab_as[idx];
        b_signed = tab_bs[idx];
        in_valid = 1'b1;
        waits    = 0;
        do begin
            @(posedge clk);
            waits = waits + 1;
        end while (!in_ready);
        entry.row          = idx;
        entry.expected     = tab_exp[idx];
        entry.accept_cycle = cycle;
        entry.timed        = timed_mode;
        pending.push_back(entry);
        #1;
    endtask

    task automatic drain_results();
        do @(posedge clk); while (pending.size() != 0);
        random_ready = 1'b0;
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int p0, input int f0);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 pass_count + fail_count - p0 - f0, fail_count - f0);
    endtask

    // out_ready is random or held high
    always @(posedge clk) begin
        int r;
        #1;
        r = $random(seed);
        out_ready = random_ready ? r[0] : 1'b1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles with %0d results missing",
                     cycle, pending.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // output monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (hold_pending) begin
                record_check(out_valid && product === held_product,
                    $sformatf("** Error at %0t: held output changed, expected %h got %h",
                              $time, held_product, product));
            end
            if (out_valid && out_ready) begin
                record_check(pending.size() != 0, "a result came out with no input pending");
                if (pending.size() != 0) begin
                    item = pending.pop_front();
                    record_check(product === item.expected,
                        $sformatf("** Error at %0t: row %0d expected %h got %h",
                                  $time, item.row, item.expected, product));
                    if (item.timed) begin
                        record_check(cycle - item.accept_cycle == 2,
                            $sformatf("** Error at %0t: row %0d latency %0d, expected 2",
                                      $time, item.row, cycle - item.accept_cycle));
                        if (last_timed_cycle >= 0) begin
                            record_check(cycle - last_timed_cycle == 1,
                                $sformatf("** Error at %0t: row %0d gap %0d cycles, expected 1",
                                          $time, item.row, cycle - last_timed_cycle));
                        end
                        last_timed_cycle = cycle;
                    end
                end
            end
            hold_pending = out_valid && !out_ready;
            held_product = product;
        end
    end

    initial begin
        int p0;
        int f0;
        int waits;
        seed             = 31;
        pass_count       = 0;
        fail_count       = 0;
        reset            = 1'b1;
        in_valid         = 1'b0;
        a                = '0;
        b                = '0;
        a_signed         = 1'b0;
        b_signed         = 1'b0;
        out_ready        = 1'b1;
        random_ready     = 1'b0;
        timed_mode       = 1'b0;
        last_timed_cycle = -1;
        hold_pending     = 1'b0;
        held_product     = '0;
        load_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        p0 = pass_count;
        f0 = fail_count;
        @(posedge clk);
        #1;
        record_check(!out_valid, $sformatf("** Error at %0t: out_valid high after reset", $time));
        record_check(in_ready, $sformatf("** Error at %0t: in_ready low after reset", $time));
        report_test(1, "reset state", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int i = 0; i < TABLE_ROWS; i++) send_row(i, waits);
        in_valid = 1'b0;
        drain_results();
        report_test(2, "directed table", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        random_ready = 1'b1;
        for (int i = TABLE_ROWS; i < ROWS; i++) send_row(i, waits);
        in_valid = 1'b0;
        drain_results();
        report_test(3, "random rows with back-pressure", p0, f0);

        // back to back with no stall
        p0 = pass_count;
        f0 = fail_count;
        timed_mode = 1'b1;
        for (int i = 0; i < TABLE_ROWS; i++) begin
            send_row(i, waits);
            record_check(waits == 1,
                $sformatf("** Error at %0t: row %0d took %0d cycles to accept, expected 1",
                          $time, i, waits));
        end
        in_valid = 1'b0;
        drain_results();
        report_test(4, "streaming latency", p0, f0);

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== source/wallace_mul32.sv ====
`timescale 1ns/100ps

module wallace_mul32 (
    input  logic               clk,
    input  logic               reset,

    // operand side
    input  logic               in_valid,
    output logic               in_ready,
    input  mul_pkg::operand_t  a,
    input  mul_pkg::operand_t  b,
    input  logic               a_signed,
    input  logic               b_signed,

    // result side
    output logic               out_valid,
    input  logic               out_ready,
    output mul_pkg::product_t  product
);

    // registered partials between the two stages
    partial_product_if pp_bus ();

    // stage 1: magnitudes, slices, sixteen 8x8 products
    partial_product_stage u_partial (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .a        (a),
        .b        (b),
        .a_signed (a_signed),
        .b_signed (b_signed),
        .pp       (pp_bus.source)
    );

    // stage 2: align, sum, sign fix
    accumulate_stage u_accumulate (
        .clk       (clk),
        .reset     (reset),
        .pp        (pp_bus.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .product   (product)
    );

endmodule

// ==== source/accumulate_stage.sv ====
`timescale 1ns/100ps

module accumulate_stage (
    input  logic               clk,
    input  logic               reset,
    partial_product_if.sink    pp,
    output logic               out_valid,
    input  logic               out_ready,
    output mul_pkg::product_t  product
);

    localparam int NUM_PARTS = mul_pkg::NUM_SLICES * mul_pkg::NUM_SLICES;
    localparam int PART_BITS = $bits(mul_pkg::partial_t);

    mul_pkg::product_t aligned [NUM_PARTS];   // zero-extended, shifted partials
    mul_pkg::product_t level1  [NUM_PARTS/2];
    mul_pkg::product_t level2  [NUM_PARTS/4];
    mul_pkg::product_t level3  [NUM_PARTS/8];
    mul_pkg::product_t total;
    mul_pkg::product_t signed_sum;
    logic              accept;

    // partial (i,j) weighs 2**(8*(i+j))
    for (genvar i = 0; i < mul_pkg::NUM_SLICES; i++) begin : g_a
        for (genvar j = 0; j < mul_pkg::NUM_SLICES; j++) begin : g_b
            localparam int IDX = i*mul_pkg::NUM_SLICES + j;
            assign aligned[IDX] =
                mul_pkg::product_t'(pp.partials[IDX*PART_BITS +: PART_BITS])
                << (mul_pkg::SLICE_BITS * (i + j));
        end
    end

    // pairwise adder tree, 16 -> 8 -> 4 -> 2 -> 1
    for (genvar k = 0; k < NUM_PARTS/2; k++) begin : g_level1
        assign level1[k] = aligned[2*k] + aligned[2*k+1];
    end

    for (genvar k = 0; k < NUM_PARTS/4; k++) begin : g_level2
        assign level2[k] = level1[2*k] + level1[2*k+1];
    end

    for (genvar k = 0; k < NUM_PARTS/8; k++) begin : g_level3
        assign level3[k] = level2[2*k] + level2[2*k+1];
    end

    assign total = level3[0] + level3[1];

    // back to two's complement when exactly one operand was negative
    always_comb begin
        if (pp.negate) begin
            signed_sum = ~total + 64'd1;
        end else begin
            signed_sum = total;
        end
    end

    assign pp.ready = ~out_valid | out_ready;
    assign accept   = pp.valid & pp.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (pp.ready) begin
            out_valid <= pp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            product <= signed_sum;
        end
    end

    a_idle_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    );

    // held result waits for the consumer
    a_hold_output: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(product)
    );

endmodule

// ==== source/partial_product_stage.sv ====
`timescale 1ns/100ps

module partial_product_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  mul_pkg::operand_t  a,
    input  mul_pkg::operand_t  b,
    input  logic               a_signed,
    input  logic               b_signed,
    partial_product_if.source  pp
);

    localparam int MSB       = $bits(mul_pkg::operand_t) - 1;
    localparam int PART_BITS = $bits(mul_pkg::partial_t);

    logic                  a_neg, b_neg;
    mul_pkg::operand_t     a_mag, b_mag;
    mul_pkg::slice_t       a_slice [mul_pkg::NUM_SLICES];
    mul_pkg::slice_t       b_slice [mul_pkg::NUM_SLICES];
    mul_pkg::partial_bus_t partials_next;
    logic                  negate_next;
    logic                  accept;

    logic                  valid_q;
    logic                  negate_q;
    mul_pkg::partial_bus_t partials_q;

    // negative only when the operand is declared signed
    assign a_neg = a_signed & a[MSB];
    assign b_neg = b_signed & b[MSB];

    assign a_mag = a_neg ? (~a + 32'd1) : a;  // two's-complement magnitude
    assign b_mag = b_neg ? (~b + 32'd1) : b;

    assign negate_next = a_neg ^ b_neg;

    for (genvar i = 0; i < mul_pkg::NUM_SLICES; i++) begin : g_slice
        assign a_slice[i] = a_mag[i*mul_pkg::SLICE_BITS +: mul_pkg::SLICE_BITS];
        assign b_slice[i] = b_mag[i*mul_pkg::SLICE_BITS +: mul_pkg::SLICE_BITS];
    end

    // every slice pair, partial (i,j) at index 4i+j
    for (genvar i = 0; i < mul_pkg::NUM_SLICES; i++) begin : g_a
        for (genvar j = 0; j < mul_pkg::NUM_SLICES; j++) begin : g_b
            wallace_8x8 u_mul (
                .a      (a_slice[i]),
                .b      (b_slice[j]),
                .result (partials_next[(i*mul_pkg::NUM_SLICES+j)*PART_BITS +: PART_BITS])
            );
        end
    end

    // empty, or draining this cycle
    assign in_ready = ~valid_q | pp.ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            partials_q <= partials_next;
            negate_q   <= negate_next;
        end
    end

    assign pp.valid    = valid_q;
    assign pp.negate   = negate_q;
    assign pp.partials = partials_q;

    // stage 2 back-pressure must freeze the bundle
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (reset)
        valid_q && !pp.ready |=> $stable(partials_q) && $stable(negate_q)
    );

endmodule

// ==== source/wallace_8x8.sv ====
`timescale 1ns/100ps

module wallace_8x8 (
    input  mul_pkg::slice_t   a,
    input  mul_pkg::slice_t   b,
    output mul_pkg::partial_t result
);

    // carry out of a row of full adders, moved up one column
    function automatic mul_pkg::partial_t carry_row(
        input mul_pkg::partial_t x,
        input mul_pkg::partial_t y,
        input mul_pkg::partial_t z
    );
        return ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    // AND rows, row i already shifted by i
    mul_pkg::partial_t pp_row [mul_pkg::SLICE_BITS];

    // layer 1: 8 rows -> 6
    mul_pkg::partial_t l1_sum0, l1_carry0;
    mul_pkg::partial_t l1_sum1, l1_carry1;

    // layer 2: 6 rows -> 4
    mul_pkg::partial_t l2_sum0, l2_carry0;
    mul_pkg::partial_t l2_sum1, l2_carry1;

    // layer 3: 4 rows -> 3
    mul_pkg::partial_t l3_sum, l3_carry;

    // layer 4: 3 rows -> 2
    mul_pkg::partial_t l4_sum, l4_carry;

    for (genvar i = 0; i < mul_pkg::SLICE_BITS; i++) begin : g_row
        assign pp_row[i] = mul_pkg::partial_t'(a & {mul_pkg::SLICE_BITS{b[i]}}) << i;
    end

    // columns where one input is always zero collapse to half adders
    assign l1_sum0   = pp_row[0] ^ pp_row[1] ^ pp_row[2];
    assign l1_carry0 = carry_row(pp_row[0], pp_row[1], pp_row[2]);
    assign l1_sum1   = pp_row[3] ^ pp_row[4] ^ pp_row[5];
    assign l1_carry1 = carry_row(pp_row[3], pp_row[4], pp_row[5]);

    // rows 6 and 7 skip layer 1
    assign l2_sum0   = l1_sum0 ^ l1_carry0 ^ l1_sum1;
    assign l2_carry0 = carry_row(l1_sum0, l1_carry0, l1_sum1);
    assign l2_sum1   = l1_carry1 ^ pp_row[6] ^ pp_row[7];
    assign l2_carry1 = carry_row(l1_carry1, pp_row[6], pp_row[7]);

    assign l3_sum    = l2_sum0 ^ l2_carry0 ^ l2_sum1;
    assign l3_carry  = carry_row(l2_sum0, l2_carry0, l2_sum1);

    assign l4_sum    = l3_sum ^ l3_carry ^ l2_carry1;
    assign l4_carry  = carry_row(l3_sum, l3_carry, l2_carry1);

    // final carry-propagate add
    // product < 2**16, so bits dropped above 15 are never needed
    assign result = l4_sum + l4_carry;

endmodule

// ==== source/partial_product_if.sv ====
`timescale 1ns/100ps

// stage 1 to stage 2 link, valid/ready handshake
interface partial_product_if;

    logic                  valid;     // partials register holds an item
    logic                  ready;     // accumulate stage can take it
    logic                  negate;    // product sign
    mul_pkg::partial_bus_t partials;  // registered 8x8 products

    modport source (
        output valid,
        output negate,
        output partials,
        input  ready
    );

    modport sink (
        input  valid,
        input  negate,
        input  partials,
        output ready
    );

endinterface

// ==== source/mul_pkg.sv ====
package mul_pkg;

    // byte-slice geometry, fixed at four slices of eight bits
    localparam int SLICE_BITS = 8;
    localparam int NUM_SLICES = 4;

    // one input operand
    typedef logic [SLICE_BITS*NUM_SLICES-1:0] operand_t;

    // full double-width product
    typedef logic [2*SLICE_BITS*NUM_SLICES-1:0] product_t;

    // one byte of an operand magnitude
    typedef logic [SLICE_BITS-1:0] slice_t;

    // one slice-by-slice product
    typedef logic [2*SLICE_BITS-1:0] partial_t;

    // sixteen partials packed lowest first
    // partial (i,j) = slice i of a times slice j of b, at index 4i+j
    typedef logic [NUM_SLICES*NUM_SLICES*2*SLICE_BITS-1:0] partial_bus_t;

endpackage
